// ==== include/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Core packet word
`define SPI_PW 40

// Payload word carried by one SPI transfer
`define SPI_DW 32

// Slave register file depth, 6-bit address space with the top unused
`define SPI_UREGS 16

// Core cycles per master SCLK half period
`define SPI_CLKDIV 2

`endif

// ==== logic/spi.sv ====
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi (
   input  logic              clk,         // Core clock
   input  logic              rst,
   // Core packet in
   input  logic              access_in,
   input  logic [`SPI_PW-1:0] packet_in,
   output logic              wait_out,
   // Core packet out
   output logic              access_out,
   output logic [`SPI_PW-1:0] packet_out,
   input  logic              wait_in,
   // Master pins
   output logic              m_sclk,
   output logic              m_mosi,
   output logic              m_ss,
   input  logic              m_miso,
   // Slave pins
   input  logic              s_sclk,
   input  logic              s_mosi,
   input  logic              s_ss,
   output logic              s_miso
);
   import spi_pkg::*;

   logic        m_access, m_wait, m_wait_out;
   logic        s_access, s_wait, s_wait_out;
   spi_packet_u m_packet, s_packet;

   // Only the addressed side can stall the core
   assign wait_out = m_wait_out | s_wait_out;

   //######################################################################
   // Master and slave side by side
   //######################################################################

   spi_master u_master (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (m_wait),
      .miso       (m_miso),
      .wait_out   (m_wait_out),
      .access_out (m_access),
      .packet_out (m_packet),
      .sclk       (m_sclk),
      .mosi       (m_mosi),
      .ss         (m_ss)
   );

   spi_slave u_slave (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (s_wait),
      .sclk       (s_sclk),
      .mosi       (s_mosi),
      .ss         (s_ss),
      .wait_out   (s_wait_out),
      .access_out (s_access),
      .packet_out (s_packet),
      .miso       (s_miso)
   );

   // Results back to the core
   spi_packet_mux u_mux (
      .clk        (clk),
      .rst        (rst),
      .m_access   (m_access),
      .m_packet   (m_packet),
      .s_access   (s_access),
      .s_packet   (s_packet),
      .wait_in    (wait_in),
      .m_wait     (m_wait),
      .s_wait     (s_wait),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// ==== logic/spi_master.sv ====
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_master (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 access_in,   // Core packet valid
   input  spi_pkg::spi_packet_u packet_in,   // Transfer command
   input  logic                 wait_in,     // Back-pressure from the mux
   input  logic                 miso,
   output logic                 wait_out,    // Core must hold its packet
   output logic                 access_out,  // Response valid
   output spi_pkg::spi_packet_u packet_out,  // Response with received word
   output logic                 sclk,
   output logic                 mosi,
   output logic                 ss
);
   import spi_pkg::*;

   localparam int BCW = $clog2(`SPI_DW);

   // FSM encoding
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_SHIFT = 2'd1;
   localparam logic [1:0] ST_RESP  = 2'd2;

   localparam logic [7:0]     HALF_LAST = 8'(`SPI_CLKDIV - 1);
   localparam logic [BCW-1:0] BIT_LAST  = BCW'(`SPI_DW - 1);

   logic [1:0]     state;
   logic [7:0]     div_cnt;    // Cycles within one SCLK half period
   logic [BCW-1:0] bit_cnt;    // Bits completed so far
   logic           half_end;   // Last cycle of a half period
   logic           start;      // Command accepted this cycle
   logic           mine;       // Packet addressed to the master
   spi_data_t      shreg;      // TX word out the top, RX bits in the bottom
   logic           rx_bit;     // MISO captured on the rise
   logic           last_q;     // Echoed reserved bit

   //######################################################################
   // Core side handshake
   //######################################################################

   assign mine     = access_in && (packet_in.m.dest == DEST_MASTER);
   assign start    = mine && (state == ST_IDLE);
   assign wait_out = mine && (state != ST_IDLE);   // Busy until response taken

   assign half_end = (div_cnt == HALF_LAST);

   //######################################################################
   // Transfer FSM and SCLK generator
   //######################################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         sclk    <= 1'b0;                       // Mode 0 idles low
         ss      <= 1'b1;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state   <= ST_SHIFT;
                  ss      <= 1'b0;             // Select one cycle after accept
                  div_cnt <= '0;
                  bit_cnt <= '0;
               end
            end
            ST_SHIFT: begin
               div_cnt <= half_end ? '0 : div_cnt + 8'd1;
               if (half_end) begin
                  sclk <= ~sclk;
                  // Falling edge closes one bit
                  if (sclk) begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == BIT_LAST) begin
                        state <= ST_RESP;      // Response valid with SS high
                        ss    <= 1'b1;
                     end
                  end
               end
            end
            ST_RESP: begin
               if (!wait_in) begin
                  state <= ST_IDLE;           // Mux took the response
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   //######################################################################
   // Data path
   //######################################################################

   always_ff @(posedge clk) begin
      if (start) begin
         shreg  <= packet_in.m.data;
         last_q <= packet_in.m.last;
      end else if ((state == ST_SHIFT) && half_end) begin
         if (!sclk) begin
            rx_bit <= miso;                    // Sample on the rise
         end else begin
            shreg <= {shreg[`SPI_DW-2:0], rx_bit};  // Next MOSI bit on the fall
         end
      end
   end

   assign mosi = shreg[`SPI_DW-1];             // MSB first

   // Response held in ST_RESP
   assign access_out = (state == ST_RESP);

   always_comb begin
      packet_out        = '0;
      packet_out.m.dest = DEST_MASTER;
      packet_out.m.last = last_q;
      packet_out.m.data = shreg;               // Fully received after last fall
   end

endmodule

// ==== logic/spi_packet_mux.sv ====
`timescale 1ns/1ns

module spi_packet_mux (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 m_access,    // Master response valid
   input  spi_pkg::spi_packet_u m_packet,
   input  logic                 s_access,    // Slave result valid
   input  spi_pkg::spi_packet_u s_packet,
   input  logic                 wait_in,     // Core back-pressure
   output logic                 m_wait,
   output logic                 s_wait,
   output logic                 access_out,
   output spi_pkg::spi_packet_u packet_out
);

   logic grant_ok;   // Output register may advance
   logic s_grant;
   logic m_grant;

   //######################################################################
   // Fixed priority grant
   //######################################################################

   // No grant while the core pushes back
   assign grant_ok = !wait_in;

   // Slave first
   assign s_grant = grant_ok && s_access;
   assign m_grant = grant_ok && m_access && !s_access;

   // Losing or stalled source holds its packet
   assign s_wait = !grant_ok;
   assign m_wait = !grant_ok || s_access;

   //######################################################################
   // Output register
   //######################################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         access_out <= 1'b0;
      end else if (grant_ok) begin
         access_out <= s_grant || m_grant;   // Empty if nothing granted
      end
   end

   always_ff @(posedge clk) begin
      if (s_grant) begin
         packet_out <= s_packet;
      end else if (m_grant) begin
         packet_out <= m_packet;
      end
   end

endmodule

// ==== logic/spi_pkg.sv ====
`include "spi_defines.svh"

package spi_pkg;

   // Destination codes in packet bit 39
   localparam logic DEST_MASTER = 1'b0;
   localparam logic DEST_SLAVE  = 1'b1;

   typedef logic [5:0]         spi_addr_t;    // Slave register address
   typedef logic [`SPI_DW-1:0] spi_data_t;    // Payload word

   // Master reading of the word, one transfer command
   typedef struct packed {
      logic      dest;   // DEST_MASTER
      logic      last;   // Reserved, echoed in the response
      logic [5:0] rsvd;
      spi_data_t data;   // Word shifted out on MOSI
   } spi_master_view_t;

   // Slave reading of the same word, one register access
   typedef struct packed {
      logic      dest;   // DEST_SLAVE
      logic      write;  // 1 write, 0 read
      spi_addr_t addr;
      spi_data_t data;
   } spi_slave_view_t;

   // One 40-bit packet, decoded by whichever side owns dest
   typedef union packed {
      spi_master_view_t m;
      spi_slave_view_t  s;
   } spi_packet_u;

endpackage

// ==== logic/spi_slave.sv ====
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_slave (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 access_in,   // Core packet valid
   input  spi_pkg::spi_packet_u packet_in,   // Register access
   input  logic                 wait_in,     // Back-pressure from the mux
   input  logic                 sclk,        // External SPI pins
   input  logic                 mosi,
   input  logic                 ss,
   output logic                 wait_out,
   output logic                 access_out,  // Read response or notification
   output spi_pkg::spi_packet_u packet_out,
   output logic                 miso
);
   import spi_pkg::*;

   localparam int RW = $clog2(`SPI_UREGS);

   localparam logic [5:0] CMD_LAST   = 6'd7;    // Last command bit
   localparam logic [5:0] DATA_FIRST = 6'd8;
   localparam logic [5:0] FRAME_LAST = 6'd39;   // 40th bit
   localparam logic [5:0] FRAME_DONE = 6'd40;
   localparam spi_addr_t  ADDR_TOP   = 6'(`SPI_UREGS);

   spi_data_t  regs [`SPI_UREGS];               // Register file

   logic [2:0] sclk_q;                          // Two sync flops plus history
   logic [1:0] mosi_q;
   logic [1:0] ss_q;
   logic       sclk_rise, sclk_fall, ss_act;

   logic [5:0] bit_cnt;                         // Bits taken in this frame
   spi_data_t  rx_sh;                           // Incoming bits
   spi_data_t  tx_sh;                           // Remaining read bits
   logic       cmd_write;
   spi_addr_t  cmd_addr;
   logic       ext_we, tx_fall;
   spi_data_t  ext_wdata, ext_rdata, core_rdata;

   logic       core_sel, core_acc, core_rd, core_we, slot_free, notif_load;

   //######################################################################
   // Pin synchronizers and edge detect
   //######################################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         sclk_q <= '0;
         mosi_q <= '0;
         ss_q   <= 2'b11;                      // Deselected
      end else begin
         sclk_q <= {sclk_q[1:0], sclk};
         mosi_q <= {mosi_q[0], mosi};
         ss_q   <= {ss_q[0], ss};
      end
   end

   assign sclk_rise = sclk_q[1] && !sclk_q[2];
   assign sclk_fall = !sclk_q[1] && sclk_q[2];
   assign ss_act    = !ss_q[1];

   //######################################################################
   // Frame decoder
   //######################################################################

   assign ext_we    = ss_act && sclk_rise && (bit_cnt == FRAME_LAST) && cmd_write;
   assign ext_wdata = {rx_sh[`SPI_DW-2:0], mosi_q[1]};
   assign ext_rdata = (cmd_addr < ADDR_TOP) ? regs[cmd_addr[RW-1:0]] : '0;
   // Read data moves on the fall through the data phase
   assign tx_fall   = ss_act && sclk_fall && !cmd_write &&
                      (bit_cnt >= DATA_FIRST) && (bit_cnt <= FRAME_LAST);

   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
         miso    <= 1'b0;
      end else if (!ss_act) begin
         bit_cnt <= '0;                        // Frame boundary
         miso    <= 1'b0;
      end else begin
         if (sclk_rise && (bit_cnt != FRAME_DONE)) begin
            bit_cnt <= bit_cnt + 6'd1;
         end
         if (tx_fall) begin
            miso <= (bit_cnt == DATA_FIRST) ? ext_rdata[`SPI_DW-1] : tx_sh[`SPI_DW-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ss_act && sclk_rise) begin
         rx_sh <= ext_wdata;                   // Shift in MSB first
         if (bit_cnt == CMD_LAST) begin
            cmd_write <= rx_sh[6];             // Bit 7 of the command
            cmd_addr  <= {rx_sh[4:0], mosi_q[1]};
         end
      end
      if (tx_fall) begin
         tx_sh <= (bit_cnt == DATA_FIRST) ? (ext_rdata << 1) : (tx_sh << 1);
      end
   end

   //######################################################################
   // Core access and register file
   //######################################################################

   assign slot_free  = !access_out || !wait_in;   // Empty or leaving now
   assign core_sel   = access_in && (packet_in.s.dest == DEST_SLAVE);
   assign wait_out   = core_sel && !slot_free;
   assign core_acc   = core_sel && slot_free;
   assign core_rd    = core_acc && !packet_in.s.write;
   assign core_we    = core_acc && packet_in.s.write;
   assign core_rdata = (packet_in.s.addr < ADDR_TOP) ? regs[packet_in.s.addr[RW-1:0]] : '0;
   assign notif_load = ext_we && slot_free && !core_rd;  // Dropped otherwise

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `SPI_UREGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (core_we && (packet_in.s.addr < ADDR_TOP)) begin
            regs[packet_in.s.addr[RW-1:0]] <= packet_in.s.data;
         end
         // External write lands last so it wins a same-address clash
         if (ext_we && (cmd_addr < ADDR_TOP)) begin
            regs[cmd_addr[RW-1:0]] <= ext_wdata;
         end
      end
   end

   //######################################################################
   // Result slot
   //######################################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         access_out <= 1'b0;
      end else if (core_rd || notif_load) begin
         access_out <= 1'b1;
      end else if (!wait_in) begin
         access_out <= 1'b0;                   // Taken by the mux
      end
   end

   always_ff @(posedge clk) begin
      if (core_rd) begin
         packet_out.s.dest  <= DEST_SLAVE;
         packet_out.s.write <= 1'b0;           // Read response
         packet_out.s.addr  <= packet_in.s.addr;
         packet_out.s.data  <= core_rdata;
      end else if (notif_load) begin
         packet_out.s.dest  <= DEST_SLAVE;
         packet_out.s.write <= 1'b1;           // Notification of external write
         packet_out.s.addr  <= cmd_addr;
         packet_out.s.data  <= ext_wdata;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module spi_tb \
   -f src.f --Mdir obj_dir -o spi_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/spi_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Verdict comes from the log
if grep -q "TB FAILED" "$LOG"; then
   exit 1
fi
exit 0

// ==== src.f ====
+incdir+include
logic/spi_pkg.sv
logic/spi_master.sv
logic/spi_slave.sv
logic/spi_packet_mux.sv
logic/spi.sv
test/spi_tb.sv

// ==== test/spi_tb.sv ====
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_tb;
   import spi_pkg::*;

   localparam int MAX_CYCLES = 20000;   // Six tests of up to ~2500 cycles plus margin
   localparam int WAIT_LIMIT = 3000;    // Per handshake

   logic clk = 1'b0;
   logic rst, access_in, wait_in, access_out, wait_out;
   logic [`SPI_PW-1:0] packet_in, packet_out;
   logic m_sclk, m_mosi, m_ss, m_miso;
   logic s_sclk, s_mosi, s_ss, s_miso;

   int seed = 32'h83d95b72;
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   logic [`SPI_PW-1:0] out_q[$];        // Packets taken by the core
   logic [`SPI_DW-1:0] dev_q[$];        // Device MISO words, one per transfer
   logic [`SPI_DW-1:0] seen_words[$];   // Words seen on m_mosi
   logic [`SPI_DW-1:0] reg_model[`SPI_UREGS];
   logic [`SPI_DW-1:0] dev_sh, dev_rx;
   int                 dev_cnt;
   logic               sclk_prev, ss_prev;

   spi uut (
      .clk(clk), .rst(rst),
      .access_in(access_in), .packet_in(packet_in), .wait_out(wait_out),
      .access_out(access_out), .packet_out(packet_out), .wait_in(wait_in),
      .m_sclk(m_sclk), .m_mosi(m_mosi), .m_ss(m_ss), .m_miso(m_miso),
      .s_sclk(s_sclk), .s_mosi(s_mosi), .s_ss(s_ss), .s_miso(s_miso)
   );

   always #2 clk = ~clk;   // 4 ns period

   //######################################################################
   // Watchdog, output monitor and SPI device model
   //######################################################################

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   // One packet per cycle with access high and wait low
   always @(negedge clk) begin
      if (!rst && access_out && !wait_in) begin
         out_q.push_back(packet_out);
      end
   end

   // Device on the master pins, mode 0
   always @(posedge clk) begin
      if (rst || m_ss !== 1'b0) begin
         if (!rst) begin
            assert (m_sclk === 1'b0) else begin
               errors++;
               $display("m_sclk toggled while m_ss was high at time %0t", $time);
            end
         end
         dev_cnt = 0;
      end else if (ss_prev === 1'b1) begin           // Frame start
         dev_sh = (dev_q.size() != 0) ? dev_q.pop_front() : '0;
         m_miso <= dev_sh[`SPI_DW-1];
      end else if (m_sclk === 1'b1 && sclk_prev === 1'b0) begin
         dev_rx = {dev_rx[`SPI_DW-2:0], m_mosi};     // Record on the rise
         dev_cnt++;
         if (dev_cnt == `SPI_DW) begin
            seen_words.push_back(dev_rx);
         end
      end else if (m_sclk === 1'b0 && sclk_prev === 1'b1) begin
         dev_sh = dev_sh << 1;                       // Next bit after the fall
         m_miso <= dev_sh[`SPI_DW-1];
      end
      ss_prev = m_ss;
      sclk_prev = m_sclk;
   end

   //######################################################################
   // Packet builders, handshakes and checks
   //######################################################################

   function automatic logic [`SPI_PW-1:0] master_word(input logic last,
                                                      input logic [`SPI_DW-1:0] data);
      return {DEST_MASTER, last, 6'b0, data};
   endfunction

   function automatic logic [`SPI_PW-1:0] slave_word(input logic wr, input logic [5:0] addr,
                                                     input logic [`SPI_DW-1:0] data);
      return {DEST_SLAVE, wr, addr, data};
   endfunction

   task check_val(input string name, input logic [`SPI_PW-1:0] got,
                  input logic [`SPI_PW-1:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      end
   endtask

   task send_packet(input logic [`SPI_PW-1:0] pkt);
      int n;
      n = 0;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(negedge clk);
      while (wait_out && n < WAIT_LIMIT) begin   // Held while the side is busy
         @(negedge clk);
         n++;
      end
      assert (!wait_out) else begin
         errors++;
         $display("Packet %h was never accepted, wait_out stayed high", pkt);
      end
      @(posedge clk);                            // Taken on this edge
      access_in <= 1'b0;
   endtask

   task wait_packet(output logic [`SPI_PW-1:0] pkt);
      int n;
      n = 0;
      pkt = '0;
      while (out_q.size() == 0 && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (out_q.size() != 0) else begin
         errors++;
         $display("No packet came out on access_out within %0d cycles", WAIT_LIMIT);
      end
      if (out_q.size() != 0) begin
         pkt = out_q.pop_front();
      end
   endtask

   task check_mosi(input logic [`SPI_DW-1:0] exp);
      assert (seen_words.size() != 0) else begin
         errors++;
         $display("No complete 32-bit word was seen on m_mosi");
      end
      if (seen_words.size() != 0) begin
         check_val("m_mosi word", seen_words.pop_front(), exp);
      end
   endtask

   task check_drained;
      repeat (20) @(negedge clk);
      assert (out_q.size() == 0) else begin
         errors++;
         $display("%0d extra packet(s) came out at time %0t", out_q.size(), $time);
         out_q.delete();
      end
   endtask

   // External SPI master on the slave pins, 4-cycle half periods
   task host_frame(input logic [7:0] cmd, input logic [`SPI_DW-1:0] wdata,
                   output logic [`SPI_DW-1:0] rdata);
      logic [`SPI_PW-1:0] bits;
      int k;
      bits = {cmd, wdata};
      rdata = '0;
      @(posedge clk);
      s_ss <= 1'b0;
      repeat (4) @(posedge clk);
      for (k = 0; k < `SPI_PW; k++) begin
         s_sclk <= 1'b0;
         s_mosi <= bits[`SPI_PW-1-k];
         repeat (4) @(posedge clk);
         if (k >= 8) begin
            rdata = {rdata[`SPI_DW-2:0], s_miso};   // Data phase bit
         end
         s_sclk <= 1'b1;
         repeat (4) @(posedge clk);
      end
      s_sclk <= 1'b0;
      repeat (4) @(posedge clk);
      s_ss <= 1'b1;
      repeat (4) @(posedge clk);
   endtask

   //######################################################################
   // Directed tests
   //######################################################################

   task reset_state;
      int a;
      logic [`SPI_PW-1:0] pkt;
      @(negedge clk);
      check_val("access_out", access_out, '0);
      check_val("wait_out", wait_out, '0);
      check_val("m_sclk", m_sclk, '0);
      check_val("m_ss", m_ss, 1);
      for (a = 0; a < `SPI_UREGS; a++) begin
         reg_model[a] = '0;
         send_packet(slave_word(1'b0, 6'(a), '0));
         wait_packet(pkt);
         check_val("packet_out", pkt, slave_word(1'b0, 6'(a), '0));
      end
   endtask

   task master_transfer;
      logic [`SPI_DW-1:0] data, word;
      logic [`SPI_PW-1:0] pkt;
      data = $random(seed);
      word = $random(seed);
      dev_q.push_back(word);
      send_packet(master_word(data[0], data));
      wait_packet(pkt);
      check_val("packet_out", pkt, master_word(data[0], word));
      check_val("m_ss", m_ss, 1);                    // Deselected after the transfer
      check_mosi(data);
      check_drained;
   endtask

   task core_register_access;
      int i;
      logic [`SPI_PW-1:0] pkt;
      for (i = 0; i < 4; i++) begin
         reg_model[i*4+2] = $random(seed);
         send_packet(slave_word(1'b1, 6'(i*4+2), reg_model[i*4+2]));
      end
      for (i = 0; i < 4; i++) begin
         send_packet(slave_word(1'b0, 6'(i*4+2), '0));
         wait_packet(pkt);
         check_val("packet_out", pkt, slave_word(1'b0, 6'(i*4+2), reg_model[i*4+2]));
      end
      check_drained;
   endtask

   task external_register_access;
      logic [`SPI_DW-1:0] data, rd;
      logic [`SPI_PW-1:0] pkt;
      data = $random(seed);
      host_frame({2'b10, 6'd7}, data, rd);
      wait_packet(pkt);
      check_val("packet_out", pkt, slave_word(1'b1, 6'd7, data));   // Notification
      reg_model[7] = data;
      send_packet(slave_word(1'b0, 6'd7, '0));
      wait_packet(pkt);
      check_val("packet_out", pkt, slave_word(1'b0, 6'd7, data));
      host_frame({2'b00, 6'd7}, '0, rd);
      check_val("s_miso word", rd, data);
      host_frame({2'b00, 6'd10}, '0, rd);            // Written by the core earlier
      check_val("s_miso word", rd, reg_model[10]);
      check_drained;
   endtask

   task priority_backpressure;
      int n;
      logic [`SPI_DW-1:0] data, word;
      logic [`SPI_PW-1:0] pkt, held;
      data = $random(seed);
      word = $random(seed);
      @(posedge clk);
      wait_in <= 1'b1;
      dev_q.push_back(word);
      send_packet(master_word(1'b1, data));
      send_packet(slave_word(1'b0, 6'd2, '0));
      n = 0;
      while ((seen_words.size() == 0 || m_ss !== 1'b1) && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      repeat (4) @(posedge clk);
      wait_in <= 1'b0;                               // One grant only
      @(posedge clk);
      wait_in <= 1'b1;
      @(negedge clk);
      held = packet_out;
      check_val("packet_out", held, slave_word(1'b0, 6'd2, reg_model[2]));
      repeat (20) begin
         @(negedge clk);
         check_val("access_out", access_out, 1);
         check_val("packet_out", packet_out, held);
      end
      @(posedge clk);
      wait_in <= 1'b0;
      wait_packet(pkt);
      check_val("packet_out", pkt, slave_word(1'b0, 6'd2, reg_model[2]));
      wait_packet(pkt);
      check_val("packet_out", pkt, master_word(1'b1, word));
      check_mosi(data);
      check_drained;
   endtask

   task random_mix;
      int i;
      int n;
      logic [31:0] r, data, word;
      logic [3:0] idx;
      logic [`SPI_PW-1:0] pkt;
      logic [`SPI_PW-1:0] exp_m[$];
      logic [`SPI_PW-1:0] exp_s[$];
      logic [`SPI_DW-1:0] exp_mosi[$];
      for (i = 0; i < 20; i++) begin
         r = $random(seed);
         data = $random(seed);
         idx = r[7:4];
         if (r[0]) begin                             // Master transfer
            word = $random(seed);
            dev_q.push_back(word);
            exp_m.push_back(master_word(r[1], word));
            exp_mosi.push_back(data);
            send_packet(master_word(r[1], data));
         end else if (r[1]) begin                    // Slave write
            reg_model[idx] = data;
            send_packet(slave_word(1'b1, {2'b00, idx}, data));
         end else begin                              // Slave read
            exp_s.push_back(slave_word(1'b0, {2'b00, idx}, reg_model[idx]));
            send_packet(slave_word(1'b0, {2'b00, idx}, data));
         end
      end
      n = exp_m.size() + exp_s.size();
      for (i = 0; i < n; i++) begin
         wait_packet(pkt);
         if (pkt[`SPI_PW-1] === DEST_MASTER && exp_m.size() != 0) begin
            check_val("packet_out", pkt, exp_m.pop_front());
         end else if (pkt[`SPI_PW-1] === DEST_SLAVE && exp_s.size() != 0) begin
            check_val("packet_out", pkt, exp_s.pop_front());
         end else begin
            errors++;
            $display("Unexpected packet %h on packet_out at time %0t", pkt, $time);
         end
      end
      while (exp_mosi.size() != 0) begin
         check_mosi(exp_mosi.pop_front());
      end
      check_drained;
   endtask

   initial begin
      rst = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      m_miso = 1'b0;
      s_sclk = 1'b0;
      s_mosi = 1'b0;
      s_ss = 1'b1;
      dev_sh = '0;
      dev_rx = '0;
      dev_cnt = 0;
      sclk_prev = 1'b0;
      ss_prev = 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      reset_state;
      master_transfer;
      core_register_access;
      external_register_access;
      priority_backpressure;
      random_mix;
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
